/* list.f */
src/mem_pkg.sv
src/bank_router.sv
src/mem_bank.sv
src/rsp_collector.sv
src/banked_mem.sv
sim/banked_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= banked_mem_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* sim/banked_mem_tb.sv */
`timescale 1ns/100ps

module banked_mem_tb
	import mem_pkg::*;
();

	localparam int CLK_HALF    = 4;
	localparam int RST_CYCLES  = 3;
	localparam int PIPE_CYCLES = LATENCY + 1; // cs cycle to output pulse

	// test lengths, one slot is one clock cycle
	localparam int PRE_SLOTS = BANK_DEPTH + 8; // runs across the rise of ready
	localparam int N_ZERO    = 40;
	localparam int N_WR      = 160;
	localparam int N_RD      = 160;
	localparam int N_B2B     = 120;
	localparam int N_SLOTS   = PRE_SLOTS + N_ZERO + N_WR + N_RD + N_B2B;

	localparam int TIMEOUT_CYCLES = BANK_DEPTH + N_SLOTS + 100;

	// one expected result, due is the cycle of its pulse
	typedef struct packed {
		logic [31:0]       due;
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} exp_t;

	logic              clk;
	logic              rst;
	logic              cs;
	logic              wen;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data_in;
	logic              ready;
	logic              rd_valid;
	logic [ADDR_W-1:0] rd_addr;
	logic [DATA_W-1:0] rd_data;
	logic              wr_done;

	integer      seed      = 6;
	logic [31:0] cyc       = '0;
	logic [31:0] ready_cyc = '1; // first cycle with ready expected high
	logic        rst_done  = 1'b0;
	int          err_cnt   = 0;
	int          accepted  = 0;

	logic [DATA_W-1:0] model [1 << ADDR_W];
	exp_t              exp_q [$];
	logic [ADDR_W-1:0] wr_addrs [$];

	banked_mem dut (
		.clk      (clk),
		.rst      (rst),
		.cs       (cs),
		.wen      (wen),
		.addr     (addr),
		.data_in  (data_in),
		.ready    (ready),
		.rd_valid (rd_valid),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.wr_done  (wr_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// cycle count and watchdog
	always @(posedge clk)
	begin
		cyc <= cyc + 32'd1;
		if (cyc >= 32'(TIMEOUT_CYCLES))
		begin
			$display("timeout at cycle %0d, the run hung with %0d results still outstanding",
				cyc, exp_q.size());
			$display("closing: %0d requests accepted, %0d errors", accepted, err_cnt + 1);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// one cycle of stimulus, the model follows only accepted requests
	task automatic drive_request(input logic req_cs, input logic req_wen,
		input logic [ADDR_W-1:0] req_addr, input logic [DATA_W-1:0] req_data);
		exp_t        e;
		logic [31:0] req_cyc;
		@(posedge clk);
		req_cyc = cyc + 32'd1; // cycle in which cs is high
		cs      <= req_cs;
		wen     <= req_wen;
		addr    <= req_addr;
		data_in <= req_data;
		if (req_cs && (req_cyc >= ready_cyc))
		begin
			e.due  = req_cyc + 32'(PIPE_CYCLES);
			e.wr   = req_wen;
			e.addr = req_addr;
			if (req_wen)
			begin
				model[req_addr] = req_data;
				e.data          = req_data;
			end
			else
			begin
				e.data = model[req_addr]; // sees every earlier write
			end
			exp_q.push_back(e);
			accepted++;
		end
	endtask

	// random traffic while the banks sweep and just after
	task automatic pre_ready_traffic();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] d;
		for (int i = 0; i < PRE_SLOTS; i++)
		begin
			w = rand_word();
			a = rand_word();
			d = rand_word();
			drive_request(w[0], w[1], a[ADDR_W-1:0], d[DATA_W-1:0]);
		end
	endtask

	task automatic zero_reads();
		logic [31:0] a;
		for (int i = 0; i < N_ZERO; i++)
		begin
			a = rand_word();
			drive_request(1'b1, 1'b0, a[ADDR_W-1:0], '0);
		end
	endtask

	task automatic random_writes();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] d;
		for (int i = 0; i < N_WR; i++)
		begin
			w = rand_word();
			a = rand_word();
			d = rand_word();
			if (w[1:0] != 2'b00)
			begin
				drive_request(1'b1, 1'b1, a[ADDR_W-1:0], d[DATA_W-1:0]);
				wr_addrs.push_back(a[ADDR_W-1:0]);
			end
			else
			begin
				drive_request(1'b0, 1'b0, '0, '0); // idle gap
			end
		end
	endtask

	// reads go back to addresses written before
	task automatic random_reads();
		logic [31:0] w;
		int          idx;
		for (int i = 0; i < N_RD; i++)
		begin
			w = rand_word();
			if ((w[1:0] != 2'b00) && (wr_addrs.size() > 0))
			begin
				idx = int'(rand_word() % 32'(wr_addrs.size()));
				drive_request(1'b1, 1'b0, wr_addrs[idx], '0);
			end
			else
			begin
				drive_request(1'b0, 1'b0, '0, '0);
			end
		end
	endtask

	// cs every cycle on one address per bank, reads and writes mixed
	task automatic back_to_back_mix();
		logic [ADDR_W-1:0] pool [NUM_BANKS];
		logic [31:0]       w;
		logic [31:0]       d;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			w       = rand_word();
			pool[b] = {w[ADDR_W-1:BANK_BITS], BANK_BITS'(b)};
		end
		for (int i = 0; i < N_B2B; i++)
		begin
			w = rand_word();
			d = rand_word();
			drive_request(1'b1, w[0], pool[w[BANK_BITS:1]], d[DATA_W-1:0]);
		end
	endtask

	// outputs are sampled mid-cycle
	always @(negedge clk)
	begin
		exp_t e;
		if (rst_done)
		begin
			check_val("ready", 32'(ready), 32'(cyc >= ready_cyc));
			if ((rd_valid === 1'b1) || (wr_done === 1'b1))
			begin
				if (exp_q.size() == 0)
				begin
					$display("unexpected output pulse at %0t with no request outstanding",
						$time);
					err_cnt++;
				end
				else
				begin
					e = exp_q.pop_front();
					check_val("pulse cycle", cyc, e.due);
					check_val("rd_valid", 32'(rd_valid), 32'(!e.wr));
					check_val("wr_done", 32'(wr_done), 32'(e.wr));
					if (!e.wr)
					begin
						check_val("rd_addr", 32'(rd_addr), 32'(e.addr));
						check_val("rd_data", 32'(rd_data), 32'(e.data));
					end
				end
			end
			else
			begin
				check_val("rd_valid", 32'(rd_valid), 32'd0); // catches unknowns too
				check_val("wr_done", 32'(wr_done), 32'd0);
				if ((exp_q.size() > 0) && (exp_q[0].due <= cyc))
				begin
					e = exp_q.pop_front();
					$display("missing output pulse at %0t, write=%0d address 0x%0h",
						$time, e.wr, e.addr);
					err_cnt++;
				end
			end
		end
	end

	initial
	begin
		for (int i = 0; i < (1 << ADDR_W); i++)
		begin
			model[i] = '0; // banks are swept to zero
		end
		rst     <= 1'b1;
		cs      <= 1'b0;
		wen     <= 1'b0;
		addr    <= '0;
		data_in <= '0;

		repeat (RST_CYCLES) @(posedge clk);
		rst       <= 1'b0;
		ready_cyc = cyc + 32'd1 + 32'(BANK_DEPTH);
		rst_done  = 1'b1;

		pre_ready_traffic();
		zero_reads();
		random_writes();
		random_reads();
		back_to_back_mix();
		drive_request(1'b0, 1'b0, '0, '0);

		// drain, the watchdog bounds this
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
		end
		repeat (8) @(posedge clk); // room for stray pulses

		$display("closing: %0d requests accepted, %0d errors", accepted, err_cnt);
		if (err_cnt == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* src/banked_mem.sv */
`timescale 1ns/100ps

module banked_mem
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              cs,
	input  logic              wen,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] data_in,
	output logic              ready,
	output logic              rd_valid,
	output logic [ADDR_W-1:0] rd_addr,
	output logic [DATA_W-1:0] rd_data,
	output logic              wr_done
);

	mem_req_t               bank_req [NUM_BANKS];
	mem_rsp_t               bank_rsp [NUM_BANKS];
	logic [NUM_BANKS-1:0]   bank_ready;

	// all banks sweep together, but wait for every one of them
	assign ready = &bank_ready;

	bank_router u_router (
		.clk      (clk),
		.rst      (rst),
		.cs       (cs),
		.wen      (wen),
		.addr     (addr),
		.data_in  (data_in),
		.ready    (ready),
		.req      (bank_req),
		.drop_cnt ()
	);

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		mem_bank u_bank (
			.clk   (clk),
			.rst   (rst),
			.req   (bank_req[b]),
			.rsp   (bank_rsp[b]),
			.ready (bank_ready[b])
		);
	end

	// one register stage on the way out
	rsp_collector u_collector (
		.clk      (clk),
		.rst      (rst),
		.rsp      (bank_rsp),
		.rd_valid (rd_valid),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.wr_done  (wr_done)
	);

endmodule

/* src/rsp_collector.sv */
`timescale 1ns/100ps

module rsp_collector
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  mem_rsp_t          rsp [NUM_BANKS],
	output logic              rd_valid,
	output logic [ADDR_W-1:0] rd_addr,
	output logic [DATA_W-1:0] rd_data,
	output logic              wr_done
);

	mem_rsp_t             sel;      // the one valid bank result
	logic [BANK_BITS-1:0] sel_bank;
	logic                 sel_rd;
	logic                 sel_wr;

	// at most one bank answers per cycle
	always_comb
	begin
		sel      = '0;
		sel_bank = '0;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			if (rsp[b].valid)
			begin
				sel      = rsp[b];
				sel_bank = BANK_BITS'(b);
			end
		end
	end

	assign sel_rd = sel.valid && (sel.op == OP_READ);
	assign sel_wr = sel.valid && (sel.op == OP_WRITE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_valid <= 1'b0;
			rd_addr  <= '0;
			rd_data  <= '0;
			wr_done  <= 1'b0;
		end
		else
		begin
			rd_valid <= sel_rd;
			wr_done  <= sel_wr;
			if (sel_rd)
			begin
				rd_addr <= {sel.addr, sel_bank}; // bank index goes back in the low bits
				rd_data <= sel.data;
			end
		end
	end

endmodule

/* src/mem_bank.sv */
`timescale 1ns/100ps

module mem_bank
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  mem_req_t req,
	output mem_rsp_t rsp,
	output logic     ready
);

	bank_state_e state;
	bank_state_e state_nxt;

	// clear sweep
	logic [BANK_AW-1:0] clr_addr;
	logic               clr_last;

	// request pipeline with its tail at stage LATENCY-1
	mem_req_t pipe [LATENCY];
	mem_req_t tail;

	// storage and its single write port
	logic [DATA_W-1:0]  mem [BANK_DEPTH];
	logic               we;
	logic [BANK_AW-1:0] waddr;
	logic [DATA_W-1:0]  wdata;

	assign clr_last = (clr_addr == BANK_AW'(BANK_DEPTH - 1));

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_CLEAR:
			begin
				if (clr_last)
				begin
					state_nxt = ST_RUN;
				end
			end
			ST_RUN:
			begin
				state_nxt = ST_RUN; // stays here until the next reset
			end
			default:
			begin
				state_nxt = ST_CLEAR;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_CLEAR;
		end
		else
		begin
			state <= state_nxt;
		end
	end

	// one word per cycle while clearing
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clr_addr <= '0;
		end
		else if (state == ST_CLEAR)
		begin
			clr_addr <= clr_addr + BANK_AW'(1);
		end
	end

	assign ready = (state == ST_RUN);

	// requests step one stage per clock
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < LATENCY; i++)
			begin
				pipe[i].valid <= 1'b0;
			end
		end
		else
		begin
			pipe[0] <= req;
			for (int i = 1; i < LATENCY; i++)
			begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign tail = pipe[LATENCY-1];

	// the sweep owns the write port until the bank is running
	always_comb
	begin
		case (state)
			ST_CLEAR:
			begin
				we    = 1'b1;
				waddr = clr_addr;
				wdata = '0;
			end
			default:
			begin
				we    = tail.valid && (tail.op == OP_WRITE);
				waddr = tail.addr;
				wdata = tail.data;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// read data comes straight from the array at the tail
	assign rsp.valid = tail.valid;
	assign rsp.op    = tail.op;
	assign rsp.addr  = tail.addr;
	assign rsp.data  = mem[tail.addr];

endmodule

/* src/bank_router.sv */
`timescale 1ns/100ps

module bank_router
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              cs,
	input  logic              wen,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] data_in,
	input  logic              ready,
	output mem_req_t          req [NUM_BANKS],
	output logic [15:0]       drop_cnt
);

	logic [BANK_BITS-1:0] bank_sel;
	logic [BANK_AW-1:0]   local_addr;
	mem_op_e              op;
	logic                 accept;
	logic                 dropped;

	// low bits pick the bank, the rest is the word inside it
	assign bank_sel   = addr[BANK_BITS-1:0];
	assign local_addr = addr[ADDR_W-1:BANK_BITS];

	// wen high is a write
	assign op = wen ? OP_WRITE : OP_READ;

	// nothing goes through until every bank is swept
	assign accept  = cs && ready;
	assign dropped = cs && !ready;

	always_comb
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			req[b].valid = accept && (bank_sel == BANK_BITS'(b));
			req[b].op    = op;
			req[b].addr  = local_addr;
			req[b].data  = data_in;
		end
	end

	// debug count of requests seen while not ready
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			drop_cnt <= '0;
		end
		else if (dropped && (drop_cnt != 16'hffff))
		begin
			drop_cnt <= drop_cnt + 16'd1; // saturates
		end
	end

endmodule

/* src/mem_pkg.sv */
package mem_pkg;

	// address and data sizes
	localparam int ADDR_W    = 10;
	localparam int DATA_W    = 16;

	// bank split, low address bits pick the bank
	localparam int BANK_BITS  = 2;
	localparam int NUM_BANKS  = 1 << BANK_BITS;
	localparam int BANK_AW    = ADDR_W - BANK_BITS;
	localparam int BANK_DEPTH = 1 << BANK_AW;

	// stages between request and array access
	localparam int LATENCY    = 3;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_e;

	typedef enum logic {
		ST_CLEAR = 1'b0, // zero sweep after reset
		ST_RUN   = 1'b1
	} bank_state_e;

	// request as seen by one bank, addr is bank-local
	typedef struct packed {
		logic                valid;
		mem_op_e             op;
		logic [BANK_AW-1:0]  addr;
		logic [DATA_W-1:0]   data;
	} mem_req_t;

	// bank result, data holds the read word
	typedef struct packed {
		logic                valid;
		mem_op_e             op;
		logic [BANK_AW-1:0]  addr;
		logic [DATA_W-1:0]   data;
	} mem_rsp_t;

endpackage
